// ==== run_sim.sh ====
#!/bin/sh
# build and run the CSR stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module csr_stage_tb -f src.f -o csr_stage_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/csr_stage_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
exit 0

// ==== src.f ====
+incdir+verilog
verilog/csr_pkg.sv
verilog/csr_issue.sv
verilog/csr_counters.sv
verilog/csr_file.sv
verilog/csr_writeback.sv
verilog/csr_stage.sv
verification/csr_stage_tb.sv

// ==== verification/csr_stage_tb.sv ====
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_stage_tb;

    localparam int         TB_FMAX_MHZ   = 4;
    localparam int         DRAIN_LIMIT   = 200;
    localparam int         CYCLE_GAP     = 13;
    localparam int         TIME_STEPS    = 5;
    localparam logic [6:0] SYSTEM_OPCODE = 7'b1110011;
    localparam logic [2:0]  FUNCT3_LIST [6] = '{3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7};
    localparam logic [11:0] RW_ADDRS [3] = '{`CSR_ADDR_MSCRATCH, `CSR_ADDR_MCAUSE,
                                             `CSR_ADDR_MTVEC};

    logic               clk;
    logic               rst;
    logic               flush;
    csr_pkg::csr_req_t  req;
    csr_pkg::csr_resp_t resp;
    logic [31:0]        trap_vector;

    // architectural model updated in issue order
    logic [31:0] model_mscratch;
    logic [31:0] model_mcause;
    logic [31:0] model_mtvec;

    csr_pkg::csr_resp_t exp_q[$];
    bit                 free_q[$];
    logic [31:0]        vec_q[$];
    logic [31:0]        sample_q[$];
    int                 value_errors;
    int                 protocol_errors;

    csr_stage #(.fmax_mhz(TB_FMAX_MHZ)) u_dut (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .req         (req),
        .resp        (resp),
        .trap_vector (trap_vector)
    );

    always #4 clk = ~clk;

    function automatic csr_pkg::csr_insn_u csr_insn(input logic [2:0] funct3,
            input logic [11:0] addr, input logic [4:0] src, input logic [4:0] rd);
        csr_pkg::csr_insn_u w;
        w.csr.csr_addr = addr;
        w.csr.src      = src;
        w.csr.funct3   = funct3;
        w.csr.rd       = rd;
        w.csr.opcode   = SYSTEM_OPCODE;
        return w;
    endfunction

    // expected response; cycle and time low words are only known as differences
    function automatic csr_pkg::csr_resp_t predict_resp(input csr_pkg::csr_insn_u insn,
            input logic [31:0] rs1_data, output bit rdata_free);
        csr_pkg::csr_resp_t r;
        logic [31:0]        operand;
        logic [31:0]        old;
        logic [31:0]        new_val;
        logic [11:0]        addr;
        logic               is_ecall;
        logic               known;
        logic               counter;
        logic               writes;
        logic               illegal;
        is_ecall   = (insn.sys.funct3 == 3'd0) && (insn.sys.funct12 == 12'd0);
        addr       = is_ecall ? `CSR_ADDR_MCAUSE : insn.csr.csr_addr;
        operand    = insn.csr.funct3[2] ? {27'd0, insn.csr.src} : rs1_data;
        known      = 1'b1;
        counter    = 1'b0;
        rdata_free = 1'b0;
        old        = 32'd0;
        case (addr)
            `CSR_ADDR_MSCRATCH: old = model_mscratch;
            `CSR_ADDR_MCAUSE:   old = model_mcause;
            `CSR_ADDR_MTVEC:    old = model_mtvec;
            `CSR_ADDR_CYCLE, `CSR_ADDR_TIME: begin
                counter    = 1'b1;
                rdata_free = 1'b1;
            end
            // high halves stay zero in a run this short
            `CSR_ADDR_CYCLEH, `CSR_ADDR_TIMEH: counter = 1'b1;
            default: known = 1'b0;
        endcase
        writes  = is_ecall || (insn.csr.funct3[1:0] == 2'b01) || (insn.csr.src != 5'd0);
        illegal = !known || (counter && writes);
        case (insn.csr.funct3[1:0])
            2'b01:   new_val = operand;
            2'b10:   new_val = old | operand;
            2'b11:   new_val = old & ~operand;
            default: new_val = `CSR_CAUSE_ECALL;
        endcase
        if (!illegal && writes) begin
            case (addr)
                `CSR_ADDR_MSCRATCH: model_mscratch = new_val;
                `CSR_ADDR_MCAUSE:   model_mcause   = new_val;
                `CSR_ADDR_MTVEC:    model_mtvec    = new_val;
                default: ;
            endcase
        end
        r.valid    = 1'b1;
        r.rd       = illegal ? 5'd0 : insn.csr.rd;
        r.rdata    = old;
        r.trap     = is_ecall;
        r.illegal  = illegal;
        rdata_free = rdata_free && !illegal;
        return r;
    endfunction

    task automatic check_resp(input csr_pkg::csr_resp_t exp, input csr_pkg::csr_resp_t act,
            input bit rdata_free);
        csr_pkg::csr_resp_t mask;
        mask = '1;
        if (rdata_free) begin
            mask.rdata = '0;
        end
        if (((exp ^ act) & mask) !== '0) begin
            $display("FAIL %0t resp: expected %h, actual %h", $time, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_vector(input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %0t trap_vector: expected %h, actual %h", $time, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_delta(input string name, input logic [31:0] lo, input logic [31:0] hi,
            input logic [31:0] act);
        if (act < lo || act > hi) begin
            $display("FAIL %0t %s delta: expected %0d..%0d, actual %0d", $time, name, lo, hi,
                     act);
            value_errors++;
        end
    endtask

    task automatic send(input csr_pkg::csr_insn_u insn, input logic [31:0] rs1_data,
            input logic kill);
        csr_pkg::csr_resp_t exp;
        bit                 free;
        @(negedge clk);
        req.valid    = 1'b1;
        req.insn     = insn;
        req.rs1_data = rs1_data;
        flush        = kill;
        // a killed request leaves the model untouched
        if (!kill) begin
            exp = predict_resp(insn, rs1_data, free);
            exp_q.push_back(exp);
            free_q.push_back(free);
            vec_q.push_back(model_mtvec);
        end
    endtask

    task automatic read_csr(input logic [11:0] addr, input logic [4:0] rd);
        send(csr_insn(3'b010, addr, 5'd0, rd), 32'd0, 1'b0);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            req.valid = 1'b0;
            flush     = 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        idle(1);
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d responses still missing", exp_q.size());
            protocol_errors++;
            exp_q.delete();
            free_q.delete();
            vec_q.delete();
        end
    endtask

    always @(posedge clk) begin
        csr_pkg::csr_resp_t exp_item;
        bit                 free_item;
        logic [31:0]        vec_item;
        if (!rst && resp.valid) begin
            if (exp_q.size() == 0) begin
                $display("unexpected response at %0t with nothing outstanding", $time);
                protocol_errors++;
            end else begin
                exp_item  = exp_q.pop_front();
                free_item = free_q.pop_front();
                vec_item  = vec_q.pop_front();
                check_resp(exp_item, resp, free_item);
                if (free_item) begin
                    sample_q.push_back(resp.rdata);
                end
                // trap target lines up with the mtvec seen by this response
                check_vector(vec_item, trap_vector);
            end
        end
    end

    initial begin
        int          seed_ret;
        logic [2:0]  f3;
        logic [11:0] addr;
        logic [4:0]  src;
        logic [31:0] rs1;
        logic [31:0] new_mtvec;
        seed_ret        = $urandom(32'h8c27ceb0);
        clk             = 1'b0;
        rst             = 1'b1;
        flush           = 1'b0;
        req             = '0;
        value_errors    = 0;
        protocol_errors = 0;
        model_mscratch  = 32'd0;
        model_mcause    = 32'd0;
        model_mtvec     = 32'd0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // random read-modify-write that often hits the same address back to back
        addr = RW_ADDRS[0];
        for (int n = 0; n < 300; n++) begin
            f3 = FUNCT3_LIST[$urandom % 6];
            if ($urandom % 3 != 0) begin
                addr = RW_ADDRS[$urandom % 3];
            end
            src = 5'($urandom);
            rs1 = (!f3[2] && src == 5'd0) ? 32'd0 : $urandom;
            send(csr_insn(f3, addr, src, 5'($urandom)), rs1, 1'b0);
            if ($urandom % 5 == 0) begin
                idle(1);
            end
        end
        drain();

        new_mtvec = $urandom & 32'hffff_fffc;
        send(csr_insn(3'b001, `CSR_ADDR_MTVEC, 5'd7, 5'd3), new_mtvec, 1'b0);
        send(csr_insn(3'b000, 12'd0, 5'd0, 5'd0), 32'd0, 1'b0);
        read_csr(`CSR_ADDR_MCAUSE, 5'd4);
        drain();
        check_vector(new_mtvec, trap_vector);

        send(csr_insn(3'b001, `CSR_ADDR_MSCRATCH, 5'd9, 5'd5), $urandom, 1'b1);
        read_csr(`CSR_ADDR_MSCRATCH, 5'd5);
        send(csr_insn(3'b101, `CSR_ADDR_MTVEC, 5'd31, 5'd6), 32'd0, 1'b1);
        read_csr(`CSR_ADDR_MTVEC, 5'd6);
        drain();

        send(csr_insn(3'b001, 12'h7c0, 5'd1, 5'd8), $urandom, 1'b0);
        send(csr_insn(3'b001, `CSR_ADDR_CYCLE, 5'd2, 5'd9), $urandom, 1'b0);
        send(csr_insn(3'b110, `CSR_ADDR_TIME, 5'd3, 5'd10), 32'd0, 1'b0);
        read_csr(`CSR_ADDR_CYCLE, 5'd11);
        drain();
        sample_q.delete();

        read_csr(`CSR_ADDR_CYCLE, 5'd12);
        idle(CYCLE_GAP - 1);
        read_csr(`CSR_ADDR_CYCLE, 5'd13);
        send(csr_insn(3'b111, `CSR_ADDR_TIME, 5'd0, 5'd14), 32'd0, 1'b0);
        idle(TB_FMAX_MHZ * TIME_STEPS - 1);
        read_csr(`CSR_ADDR_TIME, 5'd15);
        read_csr(`CSR_ADDR_CYCLEH, 5'd16);
        read_csr(`CSR_ADDR_TIMEH, 5'd17);
        drain();
        if (sample_q.size() != 4) begin
            $display("expected 4 counter samples but collected %0d", sample_q.size());
            protocol_errors++;
        end else begin
            check_delta("cycle", CYCLE_GAP, CYCLE_GAP, sample_q[1] - sample_q[0]);
            check_delta("time", TIME_STEPS - 1, TIME_STEPS + 1, sample_q[3] - sample_q[2]);
        end

        idle(8);
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog/csr_counters.sv ====
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_counters #(
    parameter int fmax_mhz = `CSR_FMAX_MHZ
) (
    input  logic        clk,
    input  logic        rst,
    output logic [63:0] cycle,
    output logic [63:0] time_us
);

    localparam int PW = (fmax_mhz > 1) ? $clog2(fmax_mhz) : 1;
    localparam logic [PW-1:0] PRESCALE_LAST = PW'(fmax_mhz - 1);

    logic [PW-1:0] prescale;
    logic          us_tick;

    assign us_tick = (prescale == PRESCALE_LAST);

    // free running, one per edge
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prescale <= '0;
        end else if (us_tick) begin
            prescale <= '0;
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

    // steps once per fmax_mhz edges
    always_ff @(posedge clk) begin
        if (rst) begin
            time_us <= '0;
        end else if (us_tick) begin
            time_us <= time_us + 64'd1;
        end
    end

    a_prescale_range: assert property (
        @(posedge clk) disable iff (rst)
        prescale <= PRESCALE_LAST
    );

endmodule

// ==== verilog/csr_defs.svh ====
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// default core clock, drives the microsecond prescaler
`define CSR_FMAX_MHZ 27

// machine-level read/write registers
`define CSR_ADDR_MSCRATCH 12'h340
`define CSR_ADDR_MCAUSE   12'h342
`define CSR_ADDR_MTVEC    12'h305

// user-level read-only counters
`define CSR_ADDR_CYCLE    12'hc00
`define CSR_ADDR_TIME     12'hc01
`define CSR_ADDR_CYCLEH   12'hc80
`define CSR_ADDR_TIMEH    12'hc81

// environment call from M-mode
`define CSR_CAUSE_ECALL   32'd11

`endif

// ==== verilog/csr_file.sv ====
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_file (
    input  logic               clk,
    input  logic               rst,
    input  csr_pkg::csr_op_t   op,
    input  logic [63:0]        cycle,
    input  logic [63:0]        time_us,
    output csr_pkg::csr_resp_t result,
    output logic [31:0]        mtvec
);

    logic [31:0] mscratch;
    logic [31:0] mcause;

    logic [31:0] old_value;
    logic [31:0] new_value;
    logic        known;
    logic        is_counter;
    logic        is_write;
    logic        illegal;
    logic        do_write;

    // read mux over every implemented address
    always_comb begin
        known      = 1'b1;
        is_counter = 1'b0;
        case (op.addr)
            `CSR_ADDR_MSCRATCH: old_value = mscratch;
            `CSR_ADDR_MCAUSE:   old_value = mcause;
            `CSR_ADDR_MTVEC:    old_value = mtvec;
            `CSR_ADDR_CYCLE: begin
                old_value  = cycle[31:0];
                is_counter = 1'b1;
            end
            `CSR_ADDR_TIME: begin
                old_value  = time_us[31:0];
                is_counter = 1'b1;
            end
            `CSR_ADDR_CYCLEH: begin
                old_value  = cycle[63:32];
                is_counter = 1'b1;
            end
            `CSR_ADDR_TIMEH: begin
                old_value  = time_us[63:32];
                is_counter = 1'b1;
            end
            default: begin
                old_value = 32'd0;
                known     = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (op.cmd)
            csr_pkg::CSR_W:     new_value = op.operand;
            csr_pkg::CSR_S:     new_value = old_value | op.operand;
            csr_pkg::CSR_C:     new_value = old_value & ~op.operand;
            csr_pkg::CSR_ECALL: new_value = `CSR_CAUSE_ECALL;
            default:            new_value = old_value;
        endcase
    end

    // set/clear with x0 or uimm 0 is a pure read
    assign is_write = (op.cmd == csr_pkg::CSR_W) || (op.cmd == csr_pkg::CSR_ECALL) ||
                      (((op.cmd == csr_pkg::CSR_S) || (op.cmd == csr_pkg::CSR_C)) &&
                       !op.src_zero);

    assign illegal  = op.valid && (!known || (is_counter && is_write));
    assign do_write = op.valid && !illegal && is_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            mscratch <= '0;
            mcause   <= '0;
            mtvec    <= '0;
        end else if (do_write) begin
            case (op.addr)
                `CSR_ADDR_MSCRATCH: mscratch <= new_value;
                `CSR_ADDR_MCAUSE:   mcause   <= new_value;
                `CSR_ADDR_MTVEC:    mtvec    <= new_value;
                default:            mtvec    <= mtvec;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else begin
            result.valid   <= op.valid;
            result.rd      <= op.rd;
            result.rdata   <= illegal ? 32'd0 : old_value;
            result.trap    <= op.valid && (op.cmd == csr_pkg::CSR_ECALL);
            result.illegal <= illegal;
        end
    end

    // counters stay read-only whatever the decode produced
    a_no_counter_write: assert property (
        @(posedge clk) disable iff (rst)
        do_write |-> !(op.addr inside {`CSR_ADDR_CYCLE, `CSR_ADDR_TIME,
                                       `CSR_ADDR_CYCLEH, `CSR_ADDR_TIMEH})
    );

endmodule

// ==== verilog/csr_issue.sv ====
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_issue (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  csr_pkg::csr_req_t  req,
    output csr_pkg::csr_op_t   op
);

    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

    csr_pkg::csr_op_t op_next;
    logic             is_system;

    assign is_system = (req.insn.csr.opcode == OPCODE_SYSTEM);

    always_comb begin
        op_next          = '0;
        op_next.cmd      = csr_pkg::CSR_X;
        op_next.addr     = req.insn.csr.csr_addr;
        op_next.rd       = req.insn.csr.rd;
        op_next.src_zero = (req.insn.csr.src == 5'd0);

        // immediate forms zero-extend the src field
        if (req.insn.csr.funct3[2]) begin
            op_next.operand = {27'd0, req.insn.csr.src};
        end else begin
            op_next.operand = req.rs1_data;
        end

        if (req.valid && !flush && is_system) begin
            case (req.insn.csr.funct3)
                3'b001, 3'b101: op_next.cmd = csr_pkg::CSR_W;
                3'b010, 3'b110: op_next.cmd = csr_pkg::CSR_S;
                3'b011, 3'b111: op_next.cmd = csr_pkg::CSR_C;
                3'b000: begin
                    // ebreak and xret decode as CSR_X
                    if (req.insn.sys.funct12 == 12'd0) begin
                        op_next.cmd  = csr_pkg::CSR_ECALL;
                        op_next.addr = `CSR_ADDR_MCAUSE;
                    end
                end
                default: op_next.cmd = csr_pkg::CSR_X;
            endcase
        end

        op_next.valid = (op_next.cmd != csr_pkg::CSR_X);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op <= '0;
        end else begin
            op <= op_next;
        end
    end

    // flushed slot never reaches the register file
    a_flush_kills: assert property (
        @(posedge clk) disable iff (rst)
        flush |=> !op.valid
    );

endmodule

// ==== verilog/csr_pkg.sv ====
package csr_pkg;

    typedef enum logic [2:0] {
        CSR_X     = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4
    } csr_cmd_e;

    // Zicsr layout; src is rs1 or uimm depending on funct3[2]
    typedef struct packed {
        logic [11:0] csr_addr;
        logic [4:0]  src;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } csr_view_t;

    // privileged layout, ecall is funct12 == 0
    typedef struct packed {
        logic [11:0] funct12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } sys_view_t;

    typedef union packed {
        csr_view_t csr;
        sys_view_t sys;
    } csr_insn_u;

    typedef struct packed {
        logic        valid;
        csr_insn_u   insn;
        logic [31:0] rs1_data;
    } csr_req_t;

    typedef struct packed {
        logic        valid;
        csr_cmd_e    cmd;
        logic [11:0] addr;
        logic [31:0] operand;
        logic        src_zero;
        logic [4:0]  rd;
    } csr_op_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] rdata;
        logic        trap;
        logic        illegal;
    } csr_resp_t;

endpackage

// ==== verilog/csr_stage.sv ====
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_stage #(
    parameter int fmax_mhz = `CSR_FMAX_MHZ
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  csr_pkg::csr_req_t  req,
    output csr_pkg::csr_resp_t resp,
    output logic [31:0]        trap_vector
);

    csr_pkg::csr_op_t   op;
    csr_pkg::csr_resp_t result;
    logic [63:0]        cycle;
    logic [63:0]        time_us;
    logic [31:0]        mtvec;

    csr_issue u_issue (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .req   (req),
        .op    (op)
    );

    csr_counters #(
        .fmax_mhz (fmax_mhz)
    ) u_counters (
        .clk     (clk),
        .rst     (rst),
        .cycle   (cycle),
        .time_us (time_us)
    );

    csr_file u_file (
        .clk     (clk),
        .rst     (rst),
        .op      (op),
        .cycle   (cycle),
        .time_us (time_us),
        .result  (result),
        .mtvec   (mtvec)
    );

    csr_writeback u_writeback (
        .clk         (clk),
        .rst         (rst),
        .result      (result),
        .mtvec       (mtvec),
        .resp        (resp),
        .trap_vector (trap_vector)
    );

endmodule

// ==== verilog/csr_writeback.sv ====
`timescale 1ns/1ps

module csr_writeback (
    input  logic               clk,
    input  logic               rst,
    input  csr_pkg::csr_resp_t result,
    input  logic [31:0]        mtvec,
    output csr_pkg::csr_resp_t resp,
    output logic [31:0]        trap_vector
);

    csr_pkg::csr_resp_t resp_next;

    always_comb begin
        resp_next = result;
        // rejected access must not touch the register file
        if (result.illegal) begin
            resp_next.rd = 5'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp <= '0;
        end else begin
            resp <= resp_next;
        end
    end

    // trap target lags mtvec by one register
    always_ff @(posedge clk) begin
        if (rst) begin
            trap_vector <= '0;
        end else begin
            trap_vector <= mtvec;
        end
    end

    // ecall always hits mcause, so it can never be rejected
    a_trap_not_illegal: assert property (
        @(posedge clk) disable iff (rst)
        result.valid |-> !(result.trap && result.illegal)
    );

endmodule
